// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing -j 0
LINT      := --lint-only --timing
TOP       := ls_unit_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram (
    input  wire                    clk,
    input  wire ls_pkg::ram_req_t  ram_req,
    output ls_pkg::word_t          rdata
);

    import ls_pkg::*;

    word_t                    mem [RAM_DEPTH];
    logic [RAM_ADDR_BITS-1:0] idx;

    // upper address bits alias
    assign idx = ram_req.addr[RAM_ADDR_BITS+1:2];

    always_ff @(posedge clk) begin
        if (ram_req.en) begin
            for (int i = 0; i < BYTE_EN_BITS; i++) begin
                if (ram_req.wen[i]) begin
                    mem[idx][8*i +: 8] <= ram_req.wdata[8*i +: 8];
                end
            end
            rdata <= mem[idx];   // read-before-write
        end
    end

endmodule

`default_nettype wire

// ==== hw/load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    issue_load,
    input  wire ls_pkg::slot_t     issue_slot,
    input  wire ls_pkg::ls_sel_t   issue_sel,
    input  wire [1:0]              issue_offset,
    input  wire ls_pkg::word_t     issue_rt,
    input  wire ls_pkg::word_t     rdata,
    output ls_pkg::load_rsp_t      load_rsp
);

    import ls_pkg::*;

    logic        valid_q;
    slot_t       slot_q;
    ls_sel_t     sel_q;
    logic [1:0]  off_q;
    word_t       rt_q;
    logic [7:0]  byte_v;
    logic [15:0] half_v;
    word_t       data_v;

    // ########################################################################
    // ex/mem register
    // ########################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_load;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_load) begin
            slot_q <= issue_slot;
            sel_q  <= issue_sel;
            off_q  <= issue_offset;
            rt_q   <= issue_rt;
        end
    end

    // ########################################################################
    // alignment
    // ########################################################################

    assign byte_v = rdata[{off_q, 3'b000} +: 8];
    assign half_v = off_q[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (sel_q)
            LS_SEL_LB:  data_v = {{24{byte_v[7]}}, byte_v};
            LS_SEL_LBU: data_v = {24'h0, byte_v};
            LS_SEL_LH:  data_v = {{16{half_v[15]}}, half_v};
            LS_SEL_LHU: data_v = {16'h0, half_v};
            LS_SEL_LWL: begin
                // low k+1 memory bytes go to the top
                case (off_q)
                    2'd0:    data_v = {rdata[7:0],  rt_q[23:0]};
                    2'd1:    data_v = {rdata[15:0], rt_q[15:0]};
                    2'd2:    data_v = {rdata[23:0], rt_q[7:0]};
                    default: data_v = rdata;
                endcase
            end
            LS_SEL_LWR: begin
                // memory bytes 3..k go to the bottom
                case (off_q)
                    2'd0:    data_v = rdata;
                    2'd1:    data_v = {rt_q[31:24], rdata[31:8]};
                    2'd2:    data_v = {rt_q[31:16], rdata[31:16]};
                    default: data_v = {rt_q[31:8],  rdata[31:24]};
                endcase
            end
            default:    data_v = rdata;   // lw
        endcase
    end

    assign load_rsp = '{valid: valid_q, slot: slot_q, data: data_v};

endmodule

`default_nettype wire

// ==== hw/ls_issue_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ls_issue_ctrl (
    input  wire ls_pkg::ls_req_t   req_c,
    input  wire ls_pkg::ls_req_t   req_p,
    input  wire                    mem_c_has_exception,
    input  wire                    mem_p_has_exception,
    output logic                   c_is_data_adel,
    output logic                   c_is_data_ades,
    output logic                   p_is_data_adel,
    output logic                   p_is_data_ades,
    output ls_pkg::ram_req_t       ram_req,
    output logic                   issue_load,
    output ls_pkg::slot_t          issue_slot,
    output ls_pkg::ls_sel_t        issue_sel,
    output logic [1:0]             issue_offset,
    output ls_pkg::word_t          issue_rt
);

    import ls_pkg::*;

    logic    mem_clear;
    logic    c_grant;
    logic    p_grant;
    logic    granted;
    ls_req_t win;

    // ########################################################################
    // decode helpers
    // ########################################################################

    function automatic logic load_adel(ls_req_t r);
        logic is_half;
        logic is_word;
        is_half = (r.sel == LS_SEL_LH) || (r.sel == LS_SEL_LHU);
        is_word = (r.sel == LS_SEL_LW);
        return r.ena & ((is_half & r.addr[0]) | (is_word & (|r.addr[1:0])));
    endfunction

    function automatic logic store_ades(ls_req_t r);
        logic is_half;
        logic is_word;
        is_half = (r.sel == LS_SEL_SH);
        is_word = (r.sel == LS_SEL_SW);
        return r.ena & ((is_half & r.addr[0]) | (is_word & (|r.addr[1:0])));
    endfunction

    function automatic logic is_load(ls_sel_t sel);
        return sel inside {LS_SEL_LB, LS_SEL_LBU, LS_SEL_LH, LS_SEL_LHU,
                           LS_SEL_LW, LS_SEL_LWL, LS_SEL_LWR};
    endfunction

    function automatic byte_en_t store_wen(ls_sel_t sel, logic [1:0] k);
        byte_en_t wen;
        case (sel)
            LS_SEL_SB:  wen = byte_en_t'(1) << k;
            LS_SEL_SH: begin
                if (k[0]) begin
                    wen = 4'b0000;     // misaligned, reported as ades
                end else begin
                    wen = k[1] ? 4'b1100 : 4'b0011;
                end
            end
            LS_SEL_SW:  wen = 4'b1111;
            LS_SEL_SWL: wen = 4'b1111 >> (2'd3 - k);   // bytes 0..k
            LS_SEL_SWR: wen = 4'b1111 << k;            // bytes k..3
            default:    wen = 4'b0000;
        endcase
        return wen;
    endfunction

    function automatic word_t store_wdata(ls_sel_t sel, logic [1:0] k, word_t rt);
        word_t wdata;
        case (sel)
            LS_SEL_SB:  wdata = {4{rt[7:0]}};
            LS_SEL_SH:  wdata = {2{rt[15:0]}};
            LS_SEL_SW:  wdata = rt;
            LS_SEL_SWL: wdata = rt >> {2'd3 - k, 3'b000};
            LS_SEL_SWR: wdata = rt << {k, 3'b000};
            default:    wdata = '0;
        endcase
        return wdata;
    endfunction

    // ########################################################################
    // address errors, per slot
    // ########################################################################

    assign c_is_data_adel = load_adel(req_c);
    assign c_is_data_ades = store_ades(req_c);
    assign p_is_data_adel = load_adel(req_p);
    assign p_is_data_ades = store_ades(req_p);

    // ########################################################################
    // grant and ram request
    // ########################################################################

    assign mem_clear = ~mem_c_has_exception & ~mem_p_has_exception;
    assign c_grant   = req_c.ena & ~req_c.has_exception & mem_clear;
    assign p_grant   = req_p.ena & ~req_p.has_exception & ~req_c.has_exception & mem_clear;
    assign granted   = c_grant | p_grant;

    // only one slot carries a memory op per cycle, so a plain mux will do
    assign win = c_grant ? req_c : req_p;

    always_comb begin
        ram_req.en    = granted;
        ram_req.wen   = granted ? store_wen(win.sel, win.addr[1:0]) : '0;
        ram_req.addr  = win.addr;
        ram_req.wdata = store_wdata(win.sel, win.addr[1:0], win.rt_data);
    end

    // forwarded to the mem stage
    assign issue_load   = granted & is_load(win.sel);
    assign issue_slot   = c_grant ? SLOT_C : SLOT_P;
    assign issue_sel    = granted ? win.sel : LS_SEL_NONE;
    assign issue_offset = win.addr[1:0];
    assign issue_rt     = win.rt_data;    // old rt, for lwl/lwr merge

endmodule

`default_nettype wire

// ==== hw/ls_pkg.sv ====
`default_nettype none

package ls_pkg;

    // ########################################################################
    // widths
    // ########################################################################

    localparam int WORD_BITS     = 32;
    localparam int BYTE_EN_BITS  = WORD_BITS / 8;
    localparam int LS_SEL_BITS   = 4;
    localparam int RAM_ADDR_BITS = 8;              // word index, addr[9:2]
    localparam int RAM_DEPTH     = 1 << RAM_ADDR_BITS;

    typedef logic [WORD_BITS-1:0]    word_t;
    typedef logic [BYTE_EN_BITS-1:0] byte_en_t;    // bit i covers byte i
    typedef logic [LS_SEL_BITS-1:0]  ls_sel_t;
    typedef logic                    slot_t;

    localparam slot_t SLOT_C = 1'b0;   // older, master slot
    localparam slot_t SLOT_P = 1'b1;

    // load/store selector codes
    localparam ls_sel_t LS_SEL_NONE = 4'd0;
    localparam ls_sel_t LS_SEL_LB   = 4'd1;
    localparam ls_sel_t LS_SEL_LBU  = 4'd2;
    localparam ls_sel_t LS_SEL_LH   = 4'd3;
    localparam ls_sel_t LS_SEL_LHU  = 4'd4;
    localparam ls_sel_t LS_SEL_LW   = 4'd5;
    localparam ls_sel_t LS_SEL_LWL  = 4'd6;
    localparam ls_sel_t LS_SEL_LWR  = 4'd7;
    localparam ls_sel_t LS_SEL_SB   = 4'd8;
    localparam ls_sel_t LS_SEL_SH   = 4'd9;
    localparam ls_sel_t LS_SEL_SW   = 4'd10;
    localparam ls_sel_t LS_SEL_SWL  = 4'd11;
    localparam ls_sel_t LS_SEL_SWR  = 4'd12;

    // ########################################################################
    // bundles
    // ########################################################################

    typedef struct packed {
        logic    ena;
        ls_sel_t sel;
        word_t   addr;
        word_t   rt_data;
        logic    has_exception;
    } ls_req_t;

    typedef struct packed {
        logic     en;
        byte_en_t wen;
        word_t    addr;
        word_t    wdata;
    } ram_req_t;

    typedef struct packed {
        logic  valid;
        slot_t slot;
        word_t data;
    } load_rsp_t;

endpackage

`default_nettype wire

// ==== hw/ls_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ls_unit_top (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire ls_pkg::ls_req_t   req_c,
    input  wire ls_pkg::ls_req_t   req_p,
    input  wire                    mem_c_has_exception,
    input  wire                    mem_p_has_exception,
    output logic                   c_is_data_adel,
    output logic                   c_is_data_ades,
    output logic                   p_is_data_adel,
    output logic                   p_is_data_ades,
    output ls_pkg::load_rsp_t      load_rsp
);

    import ls_pkg::*;

    ram_req_t   ram_req;
    word_t      rdata;
    logic       issue_load;
    slot_t      issue_slot;
    ls_sel_t    issue_sel;
    logic [1:0] issue_offset;
    word_t      issue_rt;

    // ex stage
    ls_issue_ctrl i_ls_issue_ctrl (
        .req_c               (req_c),
        .req_p               (req_p),
        .mem_c_has_exception (mem_c_has_exception),
        .mem_p_has_exception (mem_p_has_exception),
        .c_is_data_adel      (c_is_data_adel),
        .c_is_data_ades      (c_is_data_ades),
        .p_is_data_adel      (p_is_data_adel),
        .p_is_data_ades      (p_is_data_ades),
        .ram_req             (ram_req),
        .issue_load          (issue_load),
        .issue_slot          (issue_slot),
        .issue_sel           (issue_sel),
        .issue_offset        (issue_offset),
        .issue_rt            (issue_rt)
    );

    data_ram i_data_ram (
        .clk     (clk),
        .ram_req (ram_req),
        .rdata   (rdata)
    );

    // mem stage
    load_align i_load_align (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_load   (issue_load),
        .issue_slot   (issue_slot),
        .issue_sel    (issue_sel),
        .issue_offset (issue_offset),
        .issue_rt     (issue_rt),
        .rdata        (rdata),
        .load_rsp     (load_rsp)
    );

endmodule

`default_nettype wire

// ==== list.f ====
hw/ls_pkg.sv
hw/ls_issue_ctrl.sv
hw/data_ram.sv
hw/load_align.sv
hw/ls_unit_top.sv
test/ls_unit_tb.sv

// ==== test/ls_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ls_unit_tb;

    import ls_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int SWEEP_LEN  = 64;

    typedef struct packed {
        slot_t   slot;
        ls_sel_t sel;
        word_t   addr;
        word_t   rt;
        logic    c_exc;
        logic    p_exc;
        logic    mem_c;
        logic    mem_p;
        logic    adel;
        logic    ades;
    } row_t;

    logic      clk = 1'b0;
    logic      rst_n;
    ls_req_t   req_c;
    ls_req_t   req_p;
    logic      mem_c_has_exception;
    logic      mem_p_has_exception;
    logic      c_is_data_adel;
    logic      c_is_data_ades;
    logic      p_is_data_adel;
    logic      p_is_data_ades;
    load_rsp_t load_rsp;

    row_t  rows[$];
    string names[$];
    word_t ref_mem [RAM_DEPTH];
    word_t lcg_state = 32'h4b443df9;
    int    num_tests = 0;
    int    errors = 0;
    int    failed_tests = 0;
    string pend_name;     // row waiting for its mem-stage check
    int    pend_err0;
    logic  pend_load;
    slot_t pend_slot;
    word_t pend_data;

    ls_unit_top i_ls_unit_top (
        .clk                 (clk),
        .rst_n               (rst_n),
        .req_c               (req_c),
        .req_p               (req_p),
        .mem_c_has_exception (mem_c_has_exception),
        .mem_p_has_exception (mem_p_has_exception),
        .c_is_data_adel      (c_is_data_adel),
        .c_is_data_ades      (c_is_data_ades),
        .p_is_data_adel      (p_is_data_adel),
        .p_is_data_ades      (p_is_data_ades),
        .load_rsp            (load_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ########################################################################
    // reference model
    // ########################################################################

    function automatic word_t lcg_next(word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic is_store_sel(ls_sel_t sel);
        return sel inside {LS_SEL_SB, LS_SEL_SH, LS_SEL_SW, LS_SEL_SWL, LS_SEL_SWR};
    endfunction

    task automatic apply_store(ls_sel_t sel, word_t addr, word_t rt);
        int    k;
        int    src;
        word_t w;
        k = int'(addr[1:0]);
        w = ref_mem[addr[9:2]];
        for (int j = 0; j < 4; j++) begin
            src = -1;   // rt byte landing in lane j
            case (sel)
                LS_SEL_SB:  src = (j == k) ? 0 : -1;
                LS_SEL_SH:  src = (j == k || j == k + 1) ? j - k : -1;
                LS_SEL_SW:  src = j;
                LS_SEL_SWL: src = (j <= k) ? j + 3 - k : -1;
                LS_SEL_SWR: src = (j >= k) ? j - k : -1;
                default:    src = -1;
            endcase
            if (src >= 0) begin
                w[8*j +: 8] = rt[8*src +: 8];
            end
        end
        ref_mem[addr[9:2]] = w;
    endtask

    function automatic word_t load_expect(ls_sel_t sel, word_t addr, word_t rt);
        int          k;
        word_t       w;
        word_t       r;
        logic [7:0]  b;
        logic [15:0] h;
        k = int'(addr[1:0]);
        w = ref_mem[addr[9:2]];
        b = w[8*k +: 8];
        h = w[16*(k/2) +: 16];
        r = rt;
        case (sel)
            LS_SEL_LB:  r = {{24{b[7]}}, b};
            LS_SEL_LBU: r = {24'h0, b};
            LS_SEL_LH:  r = {{16{h[15]}}, h};
            LS_SEL_LHU: r = {16'h0, h};
            LS_SEL_LWL: begin
                for (int j = 3 - k; j < 4; j++) begin
                    r[8*j +: 8] = w[8*(j - 3 + k) +: 8];
                end
            end
            LS_SEL_LWR: begin
                for (int j = 0; j <= 3 - k; j++) begin
                    r[8*j +: 8] = w[8*(j + k) +: 8];
                end
            end
            default:    r = w;
        endcase
        return r;
    endfunction

    // ########################################################################
    // checks
    // ########################################################################

    task automatic check_word(string name, string what, word_t exp, word_t act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s %s: expected %08h actual %08h", name, what, exp, act);
        end
    endtask

    task automatic check_flag(string name, string what, logic exp, logic act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s %s: expected %0b actual %0b", name, what, exp, act);
        end
    endtask

    task automatic check_slot(string name, string what, slot_t exp, slot_t act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s %s: expected %0d actual %0d", name, what, exp, act);
        end
    endtask

    // ########################################################################
    // stimulus table
    // ########################################################################

    task automatic add_row(string name, slot_t slot, ls_sel_t sel, word_t addr, word_t rt,
                           logic [3:0] exc, logic [1:0] flags);
        row_t r;
        r = '{slot: slot, sel: sel, addr: addr, rt: rt, c_exc: exc[3], p_exc: exc[2],
              mem_c: exc[1], mem_p: exc[0], adel: flags[1], ades: flags[0]};
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic build_table();
        ls_sel_t sel;
        word_t   addr;
        word_t   rnd;
        add_row("sw_w0", SLOT_C, LS_SEL_SW, 32'h00, 32'h11223344, 4'b0000, 2'b00);
        add_row("sw_w1", SLOT_P, LS_SEL_SW, 32'h04, 32'h55667788, 4'b0000, 2'b00);
        add_row("sw_w2", SLOT_C, LS_SEL_SW, 32'h08, 32'h8899aabb, 4'b0000, 2'b00);
        add_row("sw_w3", SLOT_P, LS_SEL_SW, 32'h0c, 32'hf0e1d2c3, 4'b0000, 2'b00);
        for (int k = 0; k < 4; k++) begin
            add_row($sformatf("sb_k%0d", k), k[0], LS_SEL_SB, 32'h04 + k, 32'ha0 + k,
                    4'b0000, 2'b00);
            add_row($sformatf("lb_k%0d", k), k[0], LS_SEL_LB, 32'h0c + k, 32'h0, 4'b0000, 2'b00);
            add_row($sformatf("lbu_k%0d", k), ~k[0], LS_SEL_LBU, 32'h04 + k, 32'h0,
                    4'b0000, 2'b00);
        end
        add_row("lw_w1", SLOT_P, LS_SEL_LW, 32'h04, 32'h0, 4'b0000, 2'b00);
        add_row("sh_k0", SLOT_C, LS_SEL_SH, 32'h00, 32'h0000beef, 4'b0000, 2'b00);
        add_row("sh_k2", SLOT_P, LS_SEL_SH, 32'h02, 32'h00001234, 4'b0000, 2'b00);
        add_row("lw_w0", SLOT_C, LS_SEL_LW, 32'h00, 32'h0, 4'b0000, 2'b00);
        for (int k = 0; k < 4; k += 2) begin
            add_row($sformatf("lh_k%0d", k), SLOT_C, LS_SEL_LH, 32'h00 + k, 32'h0,
                    4'b0000, 2'b00);
            add_row($sformatf("lhu_k%0d", k), SLOT_P, LS_SEL_LHU, 32'h0c + k, 32'h0,
                    4'b0000, 2'b00);
        end
        // word 2 restored before each partial word
        for (int k = 0; k < 4; k++) begin
            add_row($sformatf("swl_init%0d", k), SLOT_C, LS_SEL_SW, 32'h08, 32'h01020304,
                    4'b0000, 2'b00);
            add_row($sformatf("swl_k%0d", k), k[0], LS_SEL_SWL, 32'h08 + k, 32'ha1b2c3d4,
                    4'b0000, 2'b00);
            add_row($sformatf("swl_lw%0d", k), SLOT_C, LS_SEL_LW, 32'h08, 32'h0, 4'b0000, 2'b00);
            add_row($sformatf("swr_init%0d", k), SLOT_P, LS_SEL_SW, 32'h08, 32'h01020304,
                    4'b0000, 2'b00);
            add_row($sformatf("swr_k%0d", k), ~k[0], LS_SEL_SWR, 32'h08 + k, 32'ha1b2c3d4,
                    4'b0000, 2'b00);
            add_row($sformatf("swr_lw%0d", k), SLOT_P, LS_SEL_LW, 32'h08, 32'h0, 4'b0000, 2'b00);
            add_row($sformatf("lwl_k%0d", k), k[0], LS_SEL_LWL, 32'h0c + k, 32'h55aa66bb,
                    4'b0000, 2'b00);
            add_row($sformatf("lwr_k%0d", k), ~k[0], LS_SEL_LWR, 32'h0c + k, 32'h55aa66bb,
                    4'b0000, 2'b00);
        end
        // misaligned ops carry their own exception as upstream would
        add_row("adel_lh_1", SLOT_C, LS_SEL_LH, 32'h01, 32'h0, 4'b1000, 2'b10);
        add_row("adel_lhu_3", SLOT_P, LS_SEL_LHU, 32'h03, 32'h0, 4'b0100, 2'b10);
        add_row("adel_lw_2", SLOT_P, LS_SEL_LW, 32'h06, 32'h0, 4'b0100, 2'b10);
        add_row("adel_lw_1", SLOT_C, LS_SEL_LW, 32'h09, 32'h0, 4'b1000, 2'b10);
        add_row("ades_sh_1", SLOT_P, LS_SEL_SH, 32'h05, 32'hffff, 4'b0100, 2'b01);
        add_row("ades_sw_2", SLOT_C, LS_SEL_SW, 32'h02, 32'hffffffff, 4'b1000, 2'b01);
        add_row("ades_sw_3", SLOT_P, LS_SEL_SW, 32'h0f, 32'hffffffff, 4'b0100, 2'b01);
        add_row("lb_odd_ok", SLOT_P, LS_SEL_LB, 32'h07, 32'h0, 4'b0000, 2'b00);
        add_row("sb_odd_ok", SLOT_C, LS_SEL_SB, 32'h0d, 32'h7e, 4'b0000, 2'b00);
        add_row("sup_own_sw", SLOT_C, LS_SEL_SW, 32'h00, 32'hdeadbeef, 4'b1000, 2'b00);
        add_row("sup_cexc_sw", SLOT_P, LS_SEL_SW, 32'h00, 32'hdeadbeef, 4'b1000, 2'b00);
        add_row("sup_memc_sb", SLOT_C, LS_SEL_SB, 32'h01, 32'h5c, 4'b0010, 2'b00);
        add_row("sup_memp_sh", SLOT_P, LS_SEL_SH, 32'h02, 32'h5c5c, 4'b0001, 2'b00);
        add_row("sup_own_lw", SLOT_P, LS_SEL_LW, 32'h00, 32'h0, 4'b0100, 2'b00);
        add_row("sup_memc_lw", SLOT_C, LS_SEL_LW, 32'h00, 32'h0, 4'b0010, 2'b00);
        add_row("sup_cexc_lw", SLOT_P, LS_SEL_LW, 32'h00, 32'h0, 4'b1000, 2'b00);
        add_row("lw_after_sup", SLOT_C, LS_SEL_LW, 32'h00, 32'h0, 4'b0000, 2'b00);
        add_row("b2b_sw", SLOT_P, LS_SEL_SW, 32'h0c, 32'h0badf00d, 4'b0000, 2'b00);
        add_row("b2b_lw", SLOT_C, LS_SEL_LW, 32'h0c, 32'h0, 4'b0000, 2'b00);
        add_row("sw_alias", SLOT_C, LS_SEL_SW, 32'h400, 32'hcafe0123, 4'b0000, 2'b00);
        add_row("lw_alias", SLOT_P, LS_SEL_LW, 32'h000, 32'h0, 4'b0000, 2'b00);
        // random sweep of aligned ops over words 0..3
        for (int n = 0; n < SWEEP_LEN; n++) begin
            lcg_state = lcg_next(lcg_state);
            rnd = lcg_state;
            sel = rnd[19:16] % 4'd12 + 4'd1;
            addr = {28'h0, rnd[21:20], rnd[23:22]};
            if (sel inside {LS_SEL_LH, LS_SEL_LHU, LS_SEL_SH}) begin
                addr[0] = 1'b0;
            end
            if (sel inside {LS_SEL_LW, LS_SEL_SW}) begin
                addr[1:0] = 2'b00;
            end
            lcg_state = lcg_next(lcg_state);
            add_row($sformatf("sweep_%0d", n), rnd[31], sel, addr, lcg_state, 4'b0000, 2'b00);
        end
    endtask

    // ########################################################################
    // row execution
    // ########################################################################

    task automatic start_row(string name, row_t r);
        ls_req_t active;
        logic    grant;
        active = '{ena: 1'b1, sel: r.sel, addr: r.addr, rt_data: r.rt, has_exception: 1'b0};
        // idle slot carries the same op with ena low
        req_c = '{ena: 1'b0, sel: r.sel, addr: r.addr, rt_data: r.rt, has_exception: r.c_exc};
        req_p = '{ena: 1'b0, sel: r.sel, addr: r.addr, rt_data: r.rt, has_exception: r.p_exc};
        if (r.slot == SLOT_C) begin
            active.has_exception = r.c_exc;
            req_c = active;
            grant = ~r.c_exc;
        end else begin
            active.has_exception = r.p_exc;
            req_p = active;
            grant = ~r.p_exc & ~r.c_exc;   // older slot's exception blocks p
        end
        grant = grant & ~r.mem_c & ~r.mem_p;
        mem_c_has_exception = r.mem_c;
        mem_p_has_exception = r.mem_p;
        pend_name = name;
        pend_err0 = errors;
        #1;
        check_flag(name, "c_adel", (r.slot == SLOT_C) & r.adel, c_is_data_adel);
        check_flag(name, "c_ades", (r.slot == SLOT_C) & r.ades, c_is_data_ades);
        check_flag(name, "p_adel", (r.slot == SLOT_P) & r.adel, p_is_data_adel);
        check_flag(name, "p_ades", (r.slot == SLOT_P) & r.ades, p_is_data_ades);
        pend_load = grant & ~is_store_sel(r.sel);
        pend_slot = r.slot;
        pend_data = load_expect(r.sel, r.addr, r.rt);
        if (grant && is_store_sel(r.sel)) begin
            apply_store(r.sel, r.addr, r.rt);
        end
    endtask

    // one cycle after issue
    task automatic finish_row();
        check_flag(pend_name, "valid", pend_load, load_rsp.valid);
        if (pend_load) begin
            check_slot(pend_name, "slot", pend_slot, load_rsp.slot);
            check_word(pend_name, "data", pend_data, load_rsp.data);
        end
        if (errors != pend_err0) begin
            failed_tests++;
        end
        $display("%-14s %s", pend_name, (errors == pend_err0) ? "ok" : "error");
    endtask

    initial begin
        rst_n = 1'b0;
        // a load held during reset must not leave a response
        req_c = '{ena: 1'b1, sel: LS_SEL_LW, addr: '0, rt_data: '0, has_exception: 1'b0};
        req_p = '0;
        mem_c_has_exception = 1'b0;
        mem_p_has_exception = 1'b0;
        build_table();
        num_tests = rows.size();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        req_c = '0;
        check_flag("reset", "valid", 1'b0, load_rsp.valid);
        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clk);
            if (i > 0) begin
                finish_row();
            end
            start_row(names[i], rows[i]);
        end
        @(negedge clk);
        finish_row();
        req_c = '0;
        req_p = '0;
        $display("tests %0d, failed %0d, mismatches %0d", num_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (num_tests > 0);
        #((num_tests + 20) * CLK_PERIOD * 4);
        $display("watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
